// ==== design/cpuControl_defines.svh ====
// Field widths and status flag bit positions for the control unit
`ifndef CPU_CONTROL_DEFINES_SVH
`define CPU_CONTROL_DEFINES_SVH

// Instruction byte fields
`define OPCODE_WIDTH 5
`define COND_WIDTH   3

// Status register
`define FLAG_WIDTH 4

`define FLAG_Z 0 // Zero
`define FLAG_C 1 // Carry
`define FLAG_V 2 // Overflow
`define FLAG_N 3 // Negative

`endif

// ==== design/cpuControlPkg.sv ====
// Opcode, branch, sequencing state and datapath select types
`default_nettype none

`include "cpuControl_defines.svh"

package cpuControlPkg;

	typedef enum logic [`OPCODE_WIDTH-1:0] {
		ADD    = 5'b00000,
		ADDI   = 5'b00001,
		SUB    = 5'b00100,
		SUBI   = 5'b00101,
		CMP    = 5'b00110,
		AND    = 5'b01000,
		OR     = 5'b01001,
		XOR    = 5'b01010,
		LDW    = 5'b10000,
		STW    = 5'b10001,
		BRANCH = 5'b11000 // Kind held in the cond field
	} opcode_t;

	typedef enum logic [`COND_WIDTH-1:0] {
		BR, BNE, BE, BLT, BGE, BWL, RET, JMP
	} branch_t;

	typedef enum logic [1:0] {fetch, execute, interrupt} majorState_t;

	typedef enum logic [2:0] {cycle0, cycle1, cycle2, cycle3, cycle4} subCycle_t;

	// Datapath selects
	typedef enum logic [1:0] {Op1Rd1, Op1Pc} op1Sel_t;
	typedef enum logic [1:0] {Op2Imm, Op2Rd2, Op2Zero} op2Sel_t;
	typedef enum logic {ImmLong, ImmShort} immSel_t;
	typedef enum logic {Rs1Ra, Rs1Rd} rs1Sel_t;
	typedef enum logic {RwRd, RwRa} rwSel_t;
	typedef enum logic {WdAlu, WdSys} wdSel_t;
	typedef enum logic [1:0] {Pc1, PcAluOut, PcSysbus, PcInt} pcSel_t;
	typedef enum logic {LrSys, LrPc} lrSel_t;

endpackage

`default_nettype wire

// ==== design/cycleIf.sv ====
// Interface carrying major state and sub-cycle between counter, sequencer and decoder
`timescale 1ns/100ps
`default_nettype none

interface cycleIf;

	cpuControlPkg::majorState_t majorState;
	cpuControlPkg::subCycle_t   subCycle;
	logic loadCycle4; // Cycle3 goes on to cycle4
	logic stretched;  // Cycle2 held by nWait

	modport counterPort (
		input  loadCycle4,
		output subCycle, stretched
	);

	modport sequencerPort (
		input  subCycle,
		output majorState, loadCycle4
	);

	modport decoderPort (
		input majorState, subCycle, stretched
	);

endinterface

`default_nettype wire

// ==== design/cycleCounter.sv ====
// Sub-cycle counter with nWait stretching of cycle2
`timescale 1ns/100ps
`default_nettype none

module cycleCounter (
	input wire Clock,
	input wire nReset,
	input wire nWait,
	cycleIf.counterPort cyc
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			cyc.subCycle <= cpuControlPkg::cycle0;
		end else begin
			case (cyc.subCycle)
				cpuControlPkg::cycle0: cyc.subCycle <= cpuControlPkg::cycle1;
				cpuControlPkg::cycle1: cyc.subCycle <= cpuControlPkg::cycle2;
				cpuControlPkg::cycle2: begin
					if (nWait)
						cyc.subCycle <= cpuControlPkg::cycle3; // Memory has answered
				end
				cpuControlPkg::cycle3: begin
					if (cyc.loadCycle4)
						cyc.subCycle <= cpuControlPkg::cycle4;
					else
						cyc.subCycle <= cpuControlPkg::cycle0;
				end
				default: cyc.subCycle <= cpuControlPkg::cycle0;
			endcase
		end
	end

	assign cyc.stretched = (cyc.subCycle == cpuControlPkg::cycle2) && !nWait;

endmodule

`default_nettype wire

// ==== design/cycleSequencer.sv ====
// Major state machine stepping through fetch, execute and interrupt entry
`timescale 1ns/100ps
`default_nettype none

module cycleSequencer (
	input wire Clock,
	input wire nReset,
	input wire cpuControlPkg::opcode_t opcode,
	input wire intPending,
	cycleIf.sequencerPort cyc
);

	// Fetch and interrupt entry both finish in cycle4
	assign cyc.loadCycle4 = (cyc.subCycle == cpuControlPkg::cycle3) &&
		(cyc.majorState != cpuControlPkg::execute);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			cyc.majorState <= cpuControlPkg::fetch;
		end else begin
			case (cyc.majorState)
				cpuControlPkg::fetch: begin
					if (cyc.subCycle == cpuControlPkg::cycle3)
						cyc.majorState <= cpuControlPkg::execute;
				end
				cpuControlPkg::execute: begin
					case (cyc.subCycle)
						cpuControlPkg::cycle4: begin
							if (opcode != cpuControlPkg::LDW && opcode != cpuControlPkg::STW)
								cyc.majorState <= intPending ? cpuControlPkg::interrupt
									: cpuControlPkg::fetch;
						end
						cpuControlPkg::cycle3: // End of the memory access
							cyc.majorState <= intPending ? cpuControlPkg::interrupt
								: cpuControlPkg::fetch;
						default: ;
					endcase
				end
				cpuControlPkg::interrupt: begin
					if (cyc.subCycle == cpuControlPkg::cycle4)
						cyc.majorState <= cpuControlPkg::fetch;
				end
				default: cyc.majorState <= cpuControlPkg::fetch;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/interruptSync.sv ====
// nIRQ synchroniser, falling edge detect and pending request latch
`timescale 1ns/100ps
`default_nettype none

module interruptSync (
	input  wire  Clock,
	input  wire  nReset,
	input  wire  nIRQ,
	input  wire  intClear,
	output logic intPending
);

	logic irqMeta;
	logic irqSync;
	logic irqLast; // Previous synchronised level for the edge

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqMeta    <= 1'b0;
			irqSync    <= 1'b0;
			irqLast    <= 1'b0;
			intPending <= 1'b0;
		end else begin
			irqMeta <= ~nIRQ;
			irqSync <= irqMeta;
			irqLast <= irqSync;
			// A new edge wins over the clear from the entry sequence
			intPending <= (irqSync & ~irqLast) | (intPending & ~intClear);
		end
	end

endmodule

`default_nettype wire

// ==== design/statusFlags.sv ====
// Status register and branch condition evaluation
`timescale 1ns/100ps
`default_nettype none

`include "cpuControl_defines.svh"

module statusFlags (
	input  wire                     Clock,
	input  wire                     nReset,
	input  wire  [`FLAG_WIDTH-1:0]  Flags,
	input  wire                     statusWe,
	input  wire cpuControlPkg::branch_t branch,
	output logic [`FLAG_WIDTH-1:0]  StatusReg,
	output logic                    CFlag,
	output logic                    branchTaken
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			StatusReg <= '0;
		else if (statusWe)
			StatusReg <= Flags; // ALU flags only
	end

	assign CFlag = StatusReg[`FLAG_C];

	always_comb begin
		case (branch)
			cpuControlPkg::BR,
			cpuControlPkg::BWL: branchTaken = 1'b1;
			cpuControlPkg::BNE: branchTaken = !StatusReg[`FLAG_Z];
			cpuControlPkg::BE:  branchTaken = StatusReg[`FLAG_Z];
			cpuControlPkg::BLT: branchTaken = StatusReg[`FLAG_N] ^ StatusReg[`FLAG_V];
			cpuControlPkg::BGE: branchTaken = !(StatusReg[`FLAG_N] ^ StatusReg[`FLAG_V]);
			default:            branchTaken = 1'b0; // RET and JMP decode separately
		endcase
	end

endmodule

`default_nettype wire

// ==== design/controlDecoder.sv ====
// Combinational decode of datapath selects and memory strobes
`timescale 1ns/100ps
`default_nettype none

module controlDecoder (
	cycleIf.decoderPort cyc,
	input  wire cpuControlPkg::opcode_t opcode,
	input  wire cpuControlPkg::branch_t branch,
	input  wire  branchTaken,
	output logic ALE,
	output logic AluEn,
	output logic AluWe,
	output logic ENB,
	output logic IrWe,
	output logic LrEn,
	output logic LrWe,
	output logic MemEn,
	output logic nME,
	output logic nOE,
	output logic nWE,
	output logic PcEn,
	output logic PcWe,
	output logic RegWe,
	output logic statusWe,
	output logic intClear,
	output cpuControlPkg::op1Sel_t Op1Sel,
	output cpuControlPkg::op2Sel_t Op2Sel,
	output cpuControlPkg::immSel_t ImmSel,
	output cpuControlPkg::rs1Sel_t Rs1Sel,
	output cpuControlPkg::rwSel_t  RwSel,
	output cpuControlPkg::wdSel_t  WdSel,
	output cpuControlPkg::pcSel_t  PcSel,
	output cpuControlPkg::lrSel_t  LrSel
);

	always_comb begin
		// Idle bus, no writes
		ALE      = 1'b0;
		AluEn    = 1'b0;
		AluWe    = 1'b0;
		ENB      = 1'b0;
		IrWe     = 1'b0;
		LrEn     = 1'b0;
		LrWe     = 1'b0;
		MemEn    = 1'b0;
		nME      = 1'b1;
		nOE      = 1'b1;
		nWE      = 1'b1;
		PcEn     = 1'b0;
		PcWe     = 1'b0;
		RegWe    = 1'b0;
		statusWe = 1'b0;
		intClear = 1'b0;
		Op1Sel   = cpuControlPkg::Op1Rd1;
		Op2Sel   = cpuControlPkg::Op2Imm;
		ImmSel   = cpuControlPkg::ImmLong;
		Rs1Sel   = cpuControlPkg::Rs1Ra;
		RwSel    = cpuControlPkg::RwRd;
		WdSel    = cpuControlPkg::WdAlu;
		PcSel    = cpuControlPkg::Pc1;
		LrSel    = cpuControlPkg::LrSys;

		case (cyc.majorState)
			cpuControlPkg::fetch: begin
				case (cyc.subCycle)
					cpuControlPkg::cycle0: begin
						ALE  = 1'b1; // PC out as address
						PcEn = 1'b1;
					end
					cpuControlPkg::cycle1: begin
						nME   = 1'b0;
						MemEn = 1'b1;
						PcEn  = 1'b1;
					end
					cpuControlPkg::cycle2: begin
						nME   = 1'b0;
						nOE   = 1'b0;
						MemEn = 1'b1;
						ENB   = 1'b1;
						IrWe  = !cyc.stretched; // Once, when nWait is high
					end
					cpuControlPkg::cycle3: begin
						nOE   = 1'b0;
						MemEn = 1'b1;
						ENB   = 1'b1;
					end
					default: ;
				endcase
			end

			cpuControlPkg::execute: begin
				case (cyc.subCycle)
					cpuControlPkg::cycle4: begin
						case (opcode)
							cpuControlPkg::ADD, cpuControlPkg::SUB, cpuControlPkg::CMP,
							cpuControlPkg::AND, cpuControlPkg::OR, cpuControlPkg::XOR: begin
								Op2Sel   = cpuControlPkg::Op2Rd2;
								RegWe    = (opcode != cpuControlPkg::CMP); // Flags only
								statusWe = 1'b1;
								PcEn     = 1'b1;
								PcWe     = 1'b1;
							end
							cpuControlPkg::ADDI, cpuControlPkg::SUBI: begin
								ImmSel   = cpuControlPkg::ImmShort;
								RegWe    = 1'b1;
								statusWe = 1'b1;
								PcEn     = 1'b1;
								PcWe     = 1'b1;
							end
							cpuControlPkg::LDW, cpuControlPkg::STW: begin
								ImmSel = cpuControlPkg::ImmShort; // Base plus offset
								AluEn  = 1'b1;
								AluWe  = 1'b1;
							end
							cpuControlPkg::BRANCH: begin
								case (branch)
									cpuControlPkg::RET: begin
										LrEn  = 1'b1; // Link register onto the bus
										PcWe  = 1'b1;
										PcSel = cpuControlPkg::PcSysbus;
									end
									cpuControlPkg::JMP: begin
										ImmSel = cpuControlPkg::ImmShort;
										PcWe   = 1'b1;
										PcSel  = cpuControlPkg::PcAluOut;
									end
									default: begin
										Op1Sel = cpuControlPkg::Op1Pc; // PC relative target
										AluEn  = 1'b1;
										PcWe   = 1'b1;
										if (branchTaken) begin
											PcSel = cpuControlPkg::PcAluOut;
											if (branch == cpuControlPkg::BWL) begin
												LrWe  = 1'b1;
												LrSel = cpuControlPkg::LrPc;
											end
										end
									end
								endcase
							end
							default: ;
						endcase
					end
					cpuControlPkg::cycle0: begin
						ALE    = 1'b1; // Address from the ALU register
						ImmSel = cpuControlPkg::ImmShort;
						AluEn  = 1'b1;
					end
					cpuControlPkg::cycle1: begin
						nME    = 1'b0;
						MemEn  = (opcode == cpuControlPkg::LDW);
						Op2Sel = cpuControlPkg::Op2Zero;
						Rs1Sel = cpuControlPkg::Rs1Rd; // Store data passes the ALU
						AluEn  = 1'b1;
						AluWe  = 1'b1;
					end
					cpuControlPkg::cycle2: begin
						nME   = 1'b0;
						PcWe  = !cyc.stretched; // Step past the instruction
						if (opcode == cpuControlPkg::LDW) begin
							nOE   = 1'b0;
							MemEn = 1'b1;
							ENB   = 1'b1;
							WdSel = cpuControlPkg::WdSys;
							RegWe = !cyc.stretched;
						end else begin
							Op2Sel = cpuControlPkg::Op2Zero;
							AluEn  = 1'b1;
						end
					end
					cpuControlPkg::cycle3: begin
						if (opcode == cpuControlPkg::LDW) begin
							nOE   = 1'b0;
							MemEn = 1'b1;
							ENB   = 1'b1;
						end else begin
							nWE    = 1'b0; // Write strobe
							Op2Sel = cpuControlPkg::Op2Zero;
							AluEn  = 1'b1;
						end
					end
					default: ;
				endcase
			end

			cpuControlPkg::interrupt: begin
				case (cyc.subCycle)
					cpuControlPkg::cycle0: begin
						Op2Sel = cpuControlPkg::Op2Zero;
						AluEn  = 1'b1;
						AluWe  = 1'b1;
					end
					cpuControlPkg::cycle1: begin
						ALE    = 1'b1;
						Op2Sel = cpuControlPkg::Op2Zero;
						AluEn  = 1'b1;
					end
					cpuControlPkg::cycle2: begin
						nME    = 1'b0;
						Op2Sel = cpuControlPkg::Op2Zero;
						AluEn  = 1'b1;
					end
					cpuControlPkg::cycle3: begin
						nME  = 1'b0;
						nWE  = 1'b0;
						PcEn = 1'b1; // Return address out
					end
					cpuControlPkg::cycle4: begin
						PcEn     = 1'b1;
						PcWe     = 1'b1;
						PcSel    = cpuControlPkg::PcInt;
						intClear = 1'b1;
					end
					default: ;
				endcase
			end

			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/cpuControl.sv ====
// Control unit top level joining sequencing, interrupt, status and decode blocks
`timescale 1ns/100ps
`default_nettype none

`include "cpuControl_defines.svh"

module cpuControl (
	input  wire                                     Clock,
	input  wire                                     nReset,
	input  wire                                     nIRQ,
	input  wire                                     nWait,
	input  wire  [`OPCODE_WIDTH+`COND_WIDTH-1:0]    OpcodeCondIn,
	input  wire  [`FLAG_WIDTH-1:0]                  Flags,
	output logic                                    ALE,
	output logic                                    AluEn,
	output logic                                    AluWe,
	output logic                                    ENB,
	output logic                                    IrWe,
	output logic                                    LrEn,
	output logic                                    LrWe,
	output logic                                    MemEn,
	output logic                                    nME,
	output logic                                    nOE,
	output logic                                    nWE,
	output logic                                    PcEn,
	output logic                                    PcWe,
	output logic                                    RegWe,
	output logic                                    CFlag,
	output logic [`FLAG_WIDTH-1:0]                  StatusReg,
	output cpuControlPkg::op1Sel_t                  Op1Sel,
	output cpuControlPkg::op2Sel_t                  Op2Sel,
	output cpuControlPkg::immSel_t                  ImmSel,
	output cpuControlPkg::rs1Sel_t                  Rs1Sel,
	output cpuControlPkg::rwSel_t                   RwSel,
	output cpuControlPkg::wdSel_t                   WdSel,
	output cpuControlPkg::pcSel_t                   PcSel,
	output cpuControlPkg::lrSel_t                   LrSel
);

	cpuControlPkg::opcode_t opcode;
	cpuControlPkg::branch_t branch;
	logic intPending;
	logic intClear;
	logic statusWe;
	logic branchTaken;

	// Upper bits opcode, lower bits branch kind
	assign opcode = cpuControlPkg::opcode_t'(OpcodeCondIn[`OPCODE_WIDTH+`COND_WIDTH-1:`COND_WIDTH]);
	assign branch = cpuControlPkg::branch_t'(OpcodeCondIn[`COND_WIDTH-1:0]);

	cycleIf cyc ();

	cycleCounter counter (
		.Clock  (Clock),
		.nReset (nReset),
		.nWait  (nWait),
		.cyc    (cyc.counterPort)
	);

	cycleSequencer sequencer (
		.Clock      (Clock),
		.nReset     (nReset),
		.opcode     (opcode),
		.intPending (intPending),
		.cyc        (cyc.sequencerPort)
	);

	interruptSync irqSync (
		.Clock      (Clock),
		.nReset     (nReset),
		.nIRQ       (nIRQ),
		.intClear   (intClear),
		.intPending (intPending)
	);

	statusFlags status (
		.Clock       (Clock),
		.nReset      (nReset),
		.Flags       (Flags),
		.statusWe    (statusWe),
		.branch      (branch),
		.StatusReg   (StatusReg),
		.CFlag       (CFlag),
		.branchTaken (branchTaken)
	);

	controlDecoder decoder (
		.cyc         (cyc.decoderPort),
		.opcode      (opcode),
		.branch      (branch),
		.branchTaken (branchTaken),
		.ALE         (ALE),
		.AluEn       (AluEn),
		.AluWe       (AluWe),
		.ENB         (ENB),
		.IrWe        (IrWe),
		.LrEn        (LrEn),
		.LrWe        (LrWe),
		.MemEn       (MemEn),
		.nME         (nME),
		.nOE         (nOE),
		.nWE         (nWE),
		.PcEn        (PcEn),
		.PcWe        (PcWe),
		.RegWe       (RegWe),
		.statusWe    (statusWe),
		.intClear    (intClear),
		.Op1Sel      (Op1Sel),
		.Op2Sel      (Op2Sel),
		.ImmSel      (ImmSel),
		.Rs1Sel      (Rs1Sel),
		.RwSel       (RwSel),
		.WdSel       (WdSel),
		.PcSel       (PcSel),
		.LrSel       (LrSel)
	);

endmodule

`default_nettype wire

// ==== verif/cpuControlTb.sv ====
// Testbench for the control unit with random instructions, a reference sequencing model and checks
`timescale 1ns/100ps
`default_nettype none

`include "cpuControl_defines.svh"

module cpuControlTb;

	localparam int clockPeriod   = 4;
	localparam int resetCycles   = 10;
	localparam int numInstr      = 400;
	localparam int maxStall      = 3;  // Longest nWait low run in one cycle2
	localparam int longestInstr  = 14; // LDW fetch and execute plus an interrupt entry
	localparam int timeoutCycles = resetCycles + numInstr * (longestInstr + 3 * maxStall) + 50;

	logic Clock;
	logic nReset;
	logic nIRQ;
	logic nWait;
	logic [`OPCODE_WIDTH+`COND_WIDTH-1:0] OpcodeCondIn;
	logic [`FLAG_WIDTH-1:0] Flags;
	logic ALE, AluEn, AluWe, ENB, IrWe, LrEn, LrWe, MemEn;
	logic nME, nOE, nWE, PcEn, PcWe, RegWe, CFlag;
	logic [`FLAG_WIDTH-1:0] StatusReg;
	cpuControlPkg::op1Sel_t Op1Sel;
	cpuControlPkg::op2Sel_t Op2Sel;
	cpuControlPkg::immSel_t ImmSel;
	cpuControlPkg::rs1Sel_t Rs1Sel;
	cpuControlPkg::rwSel_t  RwSel;
	cpuControlPkg::wdSel_t  WdSel;
	cpuControlPkg::pcSel_t  PcSel;
	cpuControlPkg::lrSel_t  LrSel;

	// Reference model of the sequencing
	cpuControlPkg::majorState_t expMajor;
	cpuControlPkg::subCycle_t   expSub;
	cpuControlPkg::opcode_t     curOp;
	cpuControlPkg::branch_t     curBranch;
	logic [`FLAG_WIDTH-1:0] expStatus;
	logic irqMeta, irqSync, irqLast, pending; // Mirror of the nIRQ synchroniser

	integer seed;
	int mismatchCount, missCount;
	int instrDone, irqFalls, irqEntries, irqLowLeft, stallRun;
	int ldwCount, stwCount, bwlCount, retCount, stallCount;
	bit irqBusy; // Edge issued and entry not yet finished

	cpuControl dut_i (
		.Clock (Clock), .nReset (nReset), .nIRQ (nIRQ), .nWait (nWait),
		.OpcodeCondIn (OpcodeCondIn), .Flags (Flags),
		.ALE (ALE), .AluEn (AluEn), .AluWe (AluWe), .ENB (ENB), .IrWe (IrWe),
		.LrEn (LrEn), .LrWe (LrWe), .MemEn (MemEn), .nME (nME), .nOE (nOE),
		.nWE (nWE), .PcEn (PcEn), .PcWe (PcWe), .RegWe (RegWe), .CFlag (CFlag),
		.StatusReg (StatusReg), .Op1Sel (Op1Sel), .Op2Sel (Op2Sel), .ImmSel (ImmSel),
		.Rs1Sel (Rs1Sel), .RwSel (RwSel), .WdSel (WdSel), .PcSel (PcSel), .LrSel (LrSel)
	);

	initial begin
		Clock = 1'b0;
		forever #(clockPeriod / 2) Clock = ~Clock;
	end

	initial begin
		#(timeoutCycles * clockPeriod);
		$display("Timeout: the run did not finish within %0d clock cycles", timeoutCycles);
		$display("TEST FAIL");
		$finish;
	end

	task automatic logMismatch(input string msg);
		mismatchCount++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	task automatic noteUnreached(input string what);
		missCount++;
		$display("The stimulus never exercised %s", what);
	endtask

	function automatic int randBelow(input int n);
		randBelow = $unsigned($random(seed)) % n;
	endfunction

	function automatic bit isAluOp(input cpuControlPkg::opcode_t op);
		case (op)
			cpuControlPkg::ADD, cpuControlPkg::ADDI, cpuControlPkg::SUB, cpuControlPkg::SUBI,
			cpuControlPkg::CMP, cpuControlPkg::AND, cpuControlPkg::OR,
			cpuControlPkg::XOR: isAluOp = 1'b1;
			default: isAluOp = 1'b0;
		endcase
	endfunction

	// Branch condition on the stored flags
	function automatic bit branchRule(input cpuControlPkg::branch_t b,
			input logic [`FLAG_WIDTH-1:0] s);
		case (b)
			cpuControlPkg::BR, cpuControlPkg::BWL: branchRule = 1'b1;
			cpuControlPkg::BNE: branchRule = !s[`FLAG_Z];
			cpuControlPkg::BE:  branchRule = s[`FLAG_Z];
			cpuControlPkg::BLT: branchRule = s[`FLAG_N] != s[`FLAG_V];
			cpuControlPkg::BGE: branchRule = s[`FLAG_N] == s[`FLAG_V];
			default: branchRule = 1'b0;
		endcase
	endfunction

	task automatic driveInputs();
		logic [31:0] r;
		r = $random(seed);
		Flags = r[`FLAG_WIDTH-1:0];
		if (expMajor == cpuControlPkg::fetch && expSub == cpuControlPkg::cycle0) begin
			case (randBelow(13)) // New instruction held until it ends
				0: curOp = cpuControlPkg::ADD;
				1: curOp = cpuControlPkg::ADDI;
				2: curOp = cpuControlPkg::SUB;
				3: curOp = cpuControlPkg::SUBI;
				4: curOp = cpuControlPkg::CMP;
				5: curOp = cpuControlPkg::AND;
				6: curOp = cpuControlPkg::OR;
				7: curOp = cpuControlPkg::XOR;
				8: curOp = cpuControlPkg::LDW;
				9: curOp = cpuControlPkg::STW;
				default: curOp = cpuControlPkg::BRANCH;
			endcase
			curBranch = cpuControlPkg::branch_t'(r[10:8]);
			OpcodeCondIn = {curOp, curBranch};
		end
		if (expSub == cpuControlPkg::cycle2 && stallRun < maxStall && randBelow(3) == 0) begin
			nWait = 1'b0;
			stallRun++;
			stallCount++;
		end else begin
			nWait = (expSub == cpuControlPkg::cycle2) ? 1'b1 : r[16]; // Ignored outside cycle2
			stallRun = 0;
		end
		if (!nIRQ) begin
			if (irqLowLeft == 0)
				nIRQ = 1'b1;
			else
				irqLowLeft--;
		end else if (!irqBusy && instrDone < numInstr && randBelow(16) == 0) begin
			nIRQ = 1'b0;
			irqLowLeft = 2;
			irqBusy = 1'b1;
			irqFalls++;
		end
	endtask

	task automatic checkOutputs();
		bit inFetch, inExec, inInt, done2, expRegWe, expWrite, isBwl;
		inFetch = expMajor == cpuControlPkg::fetch;
		inExec = expMajor == cpuControlPkg::execute;
		inInt = expMajor == cpuControlPkg::interrupt;
		done2 = expSub == cpuControlPkg::cycle2 && nWait; // Cycle2 completes at this edge
		expRegWe = inExec && ((expSub == cpuControlPkg::cycle4 && isAluOp(curOp) &&
			curOp != cpuControlPkg::CMP) || (done2 && curOp == cpuControlPkg::LDW));
		expWrite = expSub == cpuControlPkg::cycle3 &&
			(inInt || (inExec && curOp == cpuControlPkg::STW));
		isBwl = inExec && expSub == cpuControlPkg::cycle4 && curOp == cpuControlPkg::BRANCH &&
			curBranch == cpuControlPkg::BWL;
		if (inFetch) begin
			assert (ALE == (expSub == cpuControlPkg::cycle0))
				else logMismatch("ALE not high for exactly fetch cycle0");
			assert (nME == !(expSub == cpuControlPkg::cycle1 || expSub == cpuControlPkg::cycle2))
				else logMismatch("nME not low for fetch cycle1 and cycle2");
		end
		assert (IrWe == (inFetch && done2))
			else logMismatch("IrWe outside the completed fetch cycle2");
		if (expSub == cpuControlPkg::cycle2 && !nWait)
			assert (!nME) else logMismatch("nME released while nWait is low");
		assert (RegWe == expRegWe)
			else logMismatch($sformatf("RegWe %b, expected %b", RegWe, expRegWe));
		if (inExec && done2 && curOp == cpuControlPkg::LDW)
			assert (WdSel == cpuControlPkg::WdSys) else logMismatch("LDW write data not from the bus");
		assert (nWE == !expWrite)
			else logMismatch($sformatf("nWE %b, expected %b", nWE, !expWrite));
		assert (StatusReg == expStatus && CFlag == expStatus[`FLAG_C])
			else logMismatch($sformatf("StatusReg %h, expected %h", StatusReg, expStatus));
		assert (LrWe == isBwl) else logMismatch("LrWe outside a BWL execute cycle");
		if (isBwl)
			assert (LrSel == cpuControlPkg::LrPc) else logMismatch("BWL link not taken from the PC");
		if (inExec && expSub == cpuControlPkg::cycle4 && curOp == cpuControlPkg::BRANCH) begin
			if (curBranch == cpuControlPkg::RET)
				assert (PcSel == cpuControlPkg::PcSysbus && LrEn)
					else logMismatch("RET target wrong");
			else if (curBranch != cpuControlPkg::JMP)
				assert ((PcSel == cpuControlPkg::PcAluOut) == branchRule(curBranch, expStatus))
					else logMismatch($sformatf("branch %s took PcSel %s",
						curBranch.name(), PcSel.name()));
		end
		irqEntries += (PcSel == cpuControlPkg::PcInt && PcWe); // Vector loads seen on the DUT
		if (inInt && expSub == cpuControlPkg::cycle4)
			assert (PcSel == cpuControlPkg::PcInt && PcWe)
				else logMismatch("interrupt vector not loaded");
	endtask

	task automatic stepModel();
		cpuControlPkg::subCycle_t nextSub;
		cpuControlPkg::majorState_t nextMajor;
		logic clear;
		clear = expMajor == cpuControlPkg::interrupt && expSub == cpuControlPkg::cycle4;
		if (expMajor == cpuControlPkg::execute && expSub == cpuControlPkg::cycle4 && isAluOp(curOp))
			expStatus = Flags;
		case (expSub)
			cpuControlPkg::cycle0: nextSub = cpuControlPkg::cycle1;
			cpuControlPkg::cycle1: nextSub = cpuControlPkg::cycle2;
			cpuControlPkg::cycle2: nextSub = nWait ? cpuControlPkg::cycle3 : cpuControlPkg::cycle2;
			default: nextSub = cpuControlPkg::cycle0;
		endcase
		nextMajor = expMajor;
		case (expMajor)
			cpuControlPkg::fetch: begin
				if (expSub == cpuControlPkg::cycle3) begin
					nextMajor = cpuControlPkg::execute;
					nextSub = cpuControlPkg::cycle4;
				end
			end
			cpuControlPkg::execute: begin
				if (expSub == cpuControlPkg::cycle3 || (expSub == cpuControlPkg::cycle4 &&
						curOp != cpuControlPkg::LDW && curOp != cpuControlPkg::STW)) begin
					nextMajor = pending ? cpuControlPkg::interrupt : cpuControlPkg::fetch;
					instrDone++;
					ldwCount += (curOp == cpuControlPkg::LDW);
					stwCount += (curOp == cpuControlPkg::STW);
					bwlCount += (curOp == cpuControlPkg::BRANCH && curBranch == cpuControlPkg::BWL);
					retCount += (curOp == cpuControlPkg::BRANCH && curBranch == cpuControlPkg::RET);
				end
			end
			default: begin
				if (expSub == cpuControlPkg::cycle3) begin
					nextSub = cpuControlPkg::cycle4;
				end else if (expSub == cpuControlPkg::cycle4) begin
					nextMajor = cpuControlPkg::fetch;
					irqBusy = 1'b0;
				end
			end
		endcase
		pending = (irqSync & ~irqLast) | (pending & ~clear);
		irqLast = irqSync;
		irqSync = irqMeta;
		irqMeta = ~nIRQ;
		expMajor = nextMajor;
		expSub = nextSub;
	endtask

	initial begin : stimulus
		seed = 32'h8f50_3878;
		nReset = 1'b0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		OpcodeCondIn = '0;
		Flags = '0;
		mismatchCount = 0;
		missCount = 0;
		instrDone = 0;
		irqFalls = 0;
		irqEntries = 0;
		irqLowLeft = 0;
		stallRun = 0;
		ldwCount = 0;
		stwCount = 0;
		bwlCount = 0;
		retCount = 0;
		stallCount = 0;
		irqBusy = 1'b0;
		expMajor = cpuControlPkg::fetch;
		expSub = cpuControlPkg::cycle0;
		curOp = cpuControlPkg::ADD;
		curBranch = cpuControlPkg::BR;
		expStatus = '0;
		{irqMeta, irqSync, irqLast, pending} = '0;

		repeat (resetCycles - 1) @(negedge Clock);
		#1;
		assert (ALE && nWE && nOE && nME && !IrWe && !RegWe && !PcWe && !LrWe && !AluWe)
			else logMismatch("outputs during reset are not the idle fetch cycle0");
		@(negedge Clock);
		nReset = 1'b1;

		while (instrDone < numInstr || irqBusy) begin
			driveInputs();
			#1; // Outputs settled well before the rising edge
			checkOutputs();
			stepModel();
			@(negedge Clock);
		end

		assert (irqEntries == irqFalls)
			else logMismatch($sformatf("%0d nIRQ edges gave %0d entries", irqFalls, irqEntries));
		if (ldwCount == 0) noteUnreached("an LDW instruction");
		if (stwCount == 0) noteUnreached("an STW instruction");
		if (bwlCount == 0) noteUnreached("a BWL branch");
		if (retCount == 0) noteUnreached("a RET");
		if (stallCount == 0) noteUnreached("an nWait stall");
		if (irqEntries == 0) noteUnreached("an interrupt entry");

		$display("Errors: %0d mismatches, %0d unreached checks over %0d instructions and %0d %s",
			mismatchCount, missCount, instrDone, irqEntries, "interrupts");
		if (mismatchCount == 0 && missCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+design
design/cpuControlPkg.sv
design/cycleIf.sv
design/cycleCounter.sv
design/cycleSequencer.sv
design/interruptSync.sv
design/statusFlags.sv
design/controlDecoder.sv
design/cpuControl.sv
verif/cpuControlTb.sv

// ==== Bender.yml ====
package:
  name: cpu_control

sources:
  - include_dirs:
      - design
    files:
      - design/cpuControlPkg.sv
      - design/cycleIf.sv
      - design/cycleCounter.sv
      - design/cycleSequencer.sv
      - design/interruptSync.sv
      - design/statusFlags.sv
      - design/controlDecoder.sv
      - design/cpuControl.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/cpuControlTb.sv
